// ==== compile.f ====
src/cachePkg.sv
src/lookupIf.sv
src/cfgIf.sv
src/cacheArray.sv
src/refillUnit.sv
src/cacheCtrlRegs.sv
src/dcacheTop.sv
dv/dcacheAssert.sv
dv/dcacheTb.sv

// ==== dv/dcacheAssert.sv ====
`timescale 1ns/1ps

module dcacheAssert (
    input logic clk,
    input logic rst,
    input logic coreReq,
    input logic memReq,
    input logic memRespValid,
    input logic coreBusy,
    input logic coreRespValid
);

    // one memory request may be in flight
    logic pending;
    // failures so far, read by the testbench at the end of the run
    int assertFails = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (memReq) begin
            pending <= 1'b1;
        end else if (memRespValid) begin
            pending <= 1'b0;
        end
    end

    singleOutstanding: assert property (@(posedge clk) disable iff (rst) memReq |-> !pending)
        else begin
            assertFails++;
            $error("memReq pulsed again before memRespValid returned");
        end

    // a response is only given while the sequencer is busy
    // it follows either the accepted hit or the memory answer by one cycle
    respWhileBusy: assert property (@(posedge clk) disable iff (rst)
        coreRespValid |-> coreBusy && ($past(coreReq) || $past(memRespValid)))
        else begin
            assertFails++;
            $error("coreRespValid outside a busy response cycle");
        end

    // strobes stay quiet under reset
    quietInReset: assert property (@(posedge clk) rst |=> !coreRespValid && !memReq)
        else begin
            assertFails++;
            $error("coreRespValid or memReq active during reset");
        end

endmodule

bind dcacheTop dcacheAssert uChecks (
    .clk(clk),
    .rst(rst),
    .coreReq(coreReq),
    .memReq(memReq),
    .memRespValid(memRespValid),
    .coreBusy(coreBusy),
    .coreRespValid(coreRespValid)
);

// ==== dv/dcacheTb.sv ====
`timescale 1ns/1ps

module dcacheTb import cachePkg::*; ();

    localparam int INDEX_BITS = 2;
    localparam int SETS = 1 << INDEX_BITS;
    localparam int WORD_BITS = 4;
    localparam int WAIT_LIMIT = 200;

    logic clk;
    logic rst;
    logic coreReq;
    logic coreWrite;
    logic [ADDR_W-1:0] coreAddr;
    logic [DATA_W-1:0] coreWData;
    logic [MASK_W-1:0] coreMask;
    logic coreBusy;
    logic coreRespValid;
    logic [DATA_W-1:0] coreRData;
    logic memReq;
    logic memWrite;
    logic [ADDR_W-1:0] memAddr;
    logic [DATA_W-1:0] memWData;
    logic [MASK_W-1:0] memMask;
    logic memRespValid;
    logic [DATA_W-1:0] memRData;
    logic cfgWrite;
    logic [CFG_ADDR_W-1:0] cfgAddr;
    logic [DATA_W-1:0] cfgWData;
    logic [DATA_W-1:0] cfgRData;

    // word memory behind the cache covers a 16 word window at address zero
    logic [DATA_W-1:0] mem [1 << WORD_BITS];
    logic [31:0] lfsrState;
    // shadow of the valid and tag arrays
    logic shadowValid [SETS];
    logic [ADDR_W-1:0] shadowTag [SETS];
    logic cacheOn;
    // each entry is {expected hit, expected data}
    logic [DATA_W:0] expQ [$];
    logic [DATA_W-1:0] expHits;
    logic [DATA_W-1:0] expMisses;
    logic sawMem;
    int errors;
    int checks;

    dcacheTop #(.INDEX_BITS(INDEX_BITS), .CNT_BITS(16)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] takeBits(input int n);
        logic [63:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[62:0], lfsrState[31]};
            lfsrState = lfsrStep(lfsrState);
        end
        return v;
    endfunction

    function automatic logic [ADDR_W-1:0] wordAddr(input int w);
        return ADDR_W'(w) << OFFSET_BITS;
    endfunction

    // byte lanes selected by the mask take the new data
    function automatic logic [DATA_W-1:0] mergeBytes(input logic [DATA_W-1:0] old,
            input logic [DATA_W-1:0] wd, input logic [MASK_W-1:0] mask);
        logic [DATA_W-1:0] res;
        int b;
        res = old;
        for (b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    // expected response and hit for one access
    // shadow state advances as the cache would
    function automatic logic [DATA_W:0] refModel(input logic wr, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] wd, input logic [MASK_W-1:0] mask);
        int idx;
        logic [ADDR_W-1:0] tag;
        logic hitNow;
        logic [DATA_W-1:0] word;
        idx = addr[OFFSET_BITS +: INDEX_BITS];
        tag = addr >> (OFFSET_BITS + INDEX_BITS);
        word = mem[addr[OFFSET_BITS +: WORD_BITS]];
        hitNow = cacheOn && !wr && shadowValid[idx] && (shadowTag[idx] == tag);
        if (wr) begin
            // write-through without allocate drops the line
            shadowValid[idx] = 1'b0;
            word = mergeBytes(word, wd, mask);
        end else if (cacheOn && !hitNow) begin
            shadowValid[idx] = 1'b1;
            shadowTag[idx] = tag;
        end
        return {hitNow, word};
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic waitIdle();
        int cnt;
        cnt = 0;
        while (coreBusy !== 1'b0 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (coreBusy !== 1'b0) begin
            errors++;
            $display("timeout: coreBusy never returned low");
        end
    endtask

    task automatic coreAccess(input logic wr, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] wd, input logic [MASK_W-1:0] mask);
        logic [DATA_W:0] exp;
        @(negedge clk);
        waitIdle();
        exp = refModel(wr, addr, wd, mask);
        expQ.push_back(exp);
        if (exp[DATA_W]) begin
            expHits++;
        end else if (!wr && cacheOn) begin
            expMisses++;
        end
        coreReq = 1'b1;
        coreWrite = wr;
        coreAddr = addr;
        coreWData = wd;
        coreMask = mask;
        @(negedge clk);
        coreReq = 1'b0;
        waitIdle();
    endtask

    // extra idle cycle lets a flush reach the array
    task automatic writeReg(input logic [CFG_ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(negedge clk);
        cfgWrite = 1'b1;
        cfgAddr = a;
        cfgWData = d;
        @(negedge clk);
        cfgWrite = 1'b0;
        @(negedge clk);
    endtask

    task automatic readReg(input logic [CFG_ADDR_W-1:0] a, output logic [DATA_W-1:0] v);
        @(negedge clk);
        cfgAddr = a;
        @(negedge clk);
        v = cfgRData;
    endtask

    // memory model answers 1 to 4 cycles after memReq
    initial begin
        int w;
        int lat;
        memRespValid = 1'b0;
        memRData = '0;
        forever begin
            @(negedge clk);
            if (memReq === 1'b1) begin
                w = memAddr[OFFSET_BITS +: WORD_BITS];
                if (memWrite) begin
                    mem[w] = mergeBytes(mem[w], memWData, memMask);
                end
                lat = 1 + int'(takeBits(2));
                repeat (lat) @(negedge clk);
                memRData = mem[w];
                memRespValid = 1'b1;
                @(negedge clk);
                memRespValid = 1'b0;
            end
        end
    end

    // compare each response against the queue
    // a hit shows no memReq since the last response
    initial begin
        logic [DATA_W:0] exp;
        sawMem = 1'b0;
        forever begin
            @(negedge clk);
            if (memReq === 1'b1) begin
                sawMem = 1'b1;
            end
            if (coreRespValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    errors++;
                    $display("core response arrived with no request outstanding");
                end else begin
                    exp = expQ.pop_front();
                    checkValue("coreRData", coreRData, exp[DATA_W-1:0]);
                    checkValue("cacheHit", 64'(!sawMem), 64'(exp[DATA_W]));
                end
                sawMem = 1'b0;
            end
        end
    end

    initial begin
        logic [DATA_W-1:0] regVal;
        logic [DATA_W-1:0] hitsBefore;
        logic [DATA_W-1:0] enWord;
        logic [ADDR_W-1:0] wa;
        int i;
        errors = 0;
        checks = 0;
        expHits = '0;
        expMisses = '0;
        cacheOn = 1'b1;
        lfsrState = 32'd84562;
        rst = 1'b1;
        coreReq = 1'b0;
        coreWrite = 1'b0;
        coreAddr = '0;
        coreWData = '0;
        coreMask = '0;
        cfgWrite = 1'b0;
        cfgAddr = CFG_CTRL;
        cfgWData = '0;
        enWord = DATA_W'(1) << CTRL_ENABLE_BIT;
        for (i = 0; i < (1 << WORD_BITS); i++) begin
            wa = wordAddr(i);
            mem[i] = (wa * 64'h9e3779b97f4a7c15) ^ ~wa;
        end
        for (i = 0; i < SETS; i++) begin
            shadowValid[i] = 1'b0;
            shadowTag[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // miss then hit on the same word
        coreAccess(1'b0, wordAddr(5), '0, '0);
        coreAccess(1'b0, wordAddr(5), '0, '0);
        // masked store drops the line so the reread misses
        coreAccess(1'b1, wordAddr(5), takeBits(64), 8'h0f);
        coreAccess(1'b0, wordAddr(5), '0, '0);
        // words 1 and 5 share set 1
        for (i = 0; i < 4; i++) begin
            coreAccess(1'b0, wordAddr(i[0] ? 5 : 1), '0, '0);
        end

        // fill all four sets then flush and reread
        for (i = 0; i < SETS; i++) begin
            coreAccess(1'b0, wordAddr(8 + i), '0, '0);
        end
        writeReg(CFG_CTRL, enWord | (DATA_W'(1) << CTRL_FLUSH_BIT));
        for (i = 0; i < SETS; i++) begin
            shadowValid[i] = 1'b0;
        end
        for (i = 0; i < SETS; i++) begin
            coreAccess(1'b0, wordAddr(8 + i), '0, '0);
        end

        // while disabled every read goes out and the hit count holds
        readReg(CFG_HITS, hitsBefore);
        cacheOn = 1'b0;
        writeReg(CFG_CTRL, '0);
        for (i = 0; i < SETS; i++) begin
            coreAccess(1'b0, wordAddr(8 + i), '0, '0);
        end
        readReg(CFG_HITS, regVal);
        checkValue("cfgRData hits", regVal, hitsBefore);
        readReg(CFG_CTRL, regVal);
        checkValue("cfgRData ctrl", regVal, '0);
        cacheOn = 1'b1;

        // random traffic from a cleared counter state
        writeReg(CFG_CTRL, enWord | (DATA_W'(1) << CTRL_CLEAR_BIT));
        expHits = '0;
        expMisses = '0;
        for (i = 0; i < 40; i++) begin
            coreAccess(takeBits(1), wordAddr(int'(takeBits(WORD_BITS))), takeBits(64),
                takeBits(MASK_W));
        end
        readReg(CFG_HITS, regVal);
        checkValue("cfgRData hits", regVal, expHits);
        readReg(CFG_MISSES, regVal);
        checkValue("cfgRData misses", regVal, expMisses);
        writeReg(CFG_CTRL, enWord | (DATA_W'(1) << CTRL_CLEAR_BIT));
        readReg(CFG_HITS, regVal);
        checkValue("cfgRData hits", regVal, '0);
        readReg(CFG_MISSES, regVal);
        checkValue("cfgRData misses", regVal, '0);

        if (expQ.size() != 0) begin
            errors++;
            $display("%0d expected core responses never arrived", expQ.size());
        end
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
            u_dut.uChecks.assertFails);
        if (errors == 0 && u_dut.uChecks.assertFails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== src/cacheArray.sv ====
`timescale 1ns/1ps

module cacheArray import cachePkg::*; #(
    parameter int INDEX_BITS = 2
) (
    input logic clk,
    input logic rst,
    lookupIf.slave lk
);

    localparam int SETS = 1 << INDEX_BITS;
    // tag is everything above index and byte offset
    localparam int TAG_BITS = ADDR_W - INDEX_BITS - OFFSET_BITS;

    // one way per set
    logic [DATA_W-1:0] dataMem [SETS];
    logic [TAG_BITS-1:0] tagMem [SETS];
    logic [SETS-1:0] valid;

    logic [INDEX_BITS-1:0] lookupIdx;
    logic [TAG_BITS-1:0] lookupTag;
    logic [INDEX_BITS-1:0] fillIdx;
    logic [TAG_BITS-1:0] fillTag;

    // address slicing for the lookup side
    assign lookupIdx = lk.lookupAddr[OFFSET_BITS +: INDEX_BITS];
    assign lookupTag = lk.lookupAddr[ADDR_W-1 -: TAG_BITS];

    // address slicing for the fill side
    assign fillIdx = lk.fillAddr[OFFSET_BITS +: INDEX_BITS];
    assign fillTag = lk.fillAddr[ADDR_W-1 -: TAG_BITS];

    // combinational lookup
    // valid set with matching tag is a hit
    assign lk.hit = valid[lookupIdx] && (tagMem[lookupIdx] == lookupTag);
    // data is read out regardless of hit, the sequencer qualifies it
    assign lk.hitData = dataMem[lookupIdx];

    // tag and data storage, written only on fill
    always_ff @(posedge clk) begin
        if (lk.fill) begin
            tagMem[fillIdx] <= fillTag;
            dataMem[fillIdx] <= lk.fillData;
        end
    end

    // valid bits
    // flush beats fill, and a later inval beats fill on the same set
    always_ff @(posedge clk) begin
        if (rst || lk.flushAll) begin
            valid <= '0;
        end else begin
            if (lk.fill) begin
                valid[fillIdx] <= 1'b1;
            end
            // store to a cached line drops the line, no update in place
            if (lk.inval) begin
                valid[lk.invalAddr] <= 1'b0;
            end
        end
    end

endmodule

// ==== src/cacheCtrlRegs.sv ====
`timescale 1ns/1ps

module cacheCtrlRegs import cachePkg::*; #(
    parameter int CNT_BITS = 16
) (
    input  logic clk,
    input  logic rst,
    cfgIf.regs cfg,
    input  logic cfgWrite,
    input  logic [CFG_ADDR_W-1:0] cfgAddr,
    input  logic [DATA_W-1:0] cfgWData,
    output logic [DATA_W-1:0] cfgRData
);

    logic enableR;
    logic flushR;
    logic [CNT_BITS-1:0] hitCount;
    logic [CNT_BITS-1:0] missCount;
    logic ctrlWrite;
    logic clearCnt;

    assign ctrlWrite = cfgWrite && (cfgAddr == CFG_CTRL);
    assign clearCnt = ctrlWrite && cfgWData[CTRL_CLEAR_BIT];

    // control word, cache comes up enabled
    always_ff @(posedge clk) begin
        if (rst) begin
            enableR <= 1'b1;
            flushR <= 1'b0;
        end else begin
            flushR <= ctrlWrite && cfgWData[CTRL_FLUSH_BIT];
            if (ctrlWrite) begin
                enableR <= cfgWData[CTRL_ENABLE_BIT];
            end
        end
    end

    // counters wrap, clear takes priority over a same cycle event
    always_ff @(posedge clk) begin
        if (rst || clearCnt) begin
            hitCount <= '0;
            missCount <= '0;
        end else begin
            if (cfg.hitEvent) begin
                hitCount <= hitCount + 1'b1;
            end
            if (cfg.missEvent) begin
                missCount <= missCount + 1'b1;
            end
        end
    end

    assign cfg.enable = enableR;
    assign cfg.flushReq = flushR;

    // read mux, unused bits read as zero
    always_comb begin
        cfgRData = '0;
        case (cfgAddr)
            CFG_CTRL: cfgRData[CTRL_ENABLE_BIT] = enableR;
            CFG_HITS: cfgRData[CNT_BITS-1:0] = hitCount;
            CFG_MISSES: cfgRData[CNT_BITS-1:0] = missCount;
            default: cfgRData = '0;
        endcase
    end

endmodule

// ==== src/cachePkg.sv ====
package cachePkg;

    // datapath widths of the core and memory side
    parameter int DATA_W = 64;
    parameter int MASK_W = DATA_W / 8;
    parameter int ADDR_W = 64;

    // byte offset inside one word, these address bits never reach the array
    parameter int OFFSET_BITS = 3;

    // register port address width and the register map
    parameter int CFG_ADDR_W = 2;
    parameter logic [CFG_ADDR_W-1:0] CFG_CTRL = 2'd0;
    parameter logic [CFG_ADDR_W-1:0] CFG_HITS = 2'd1;
    parameter logic [CFG_ADDR_W-1:0] CFG_MISSES = 2'd2;

    // bit positions inside the control word
    // enable is a level, flush and clear act only on the write cycle
    parameter int CTRL_ENABLE_BIT = 0;
    parameter int CTRL_FLUSH_BIT = 1;
    parameter int CTRL_CLEAR_BIT = 2;

endpackage

// ==== src/cfgIf.sv ====
`timescale 1ns/1ps

interface cfgIf;

    // from the register block
    // enable is a level, flushReq is a one cycle pulse
    logic enable;
    logic flushReq;

    // from the refill unit, one pulse per counted read
    logic hitEvent;
    logic missEvent;

    modport regs (
        output enable, flushReq,
        input  hitEvent, missEvent
    );

    modport refill (
        input  enable, flushReq,
        output hitEvent, missEvent
    );

endinterface

// ==== src/dcacheTop.sv ====
`timescale 1ns/1ps

module dcacheTop import cachePkg::*; #(
    parameter int INDEX_BITS = 2,
    parameter int CNT_BITS = 16
) (
    input  logic clk,
    input  logic rst,
    // core side
    input  logic coreReq,
    input  logic coreWrite,
    input  logic [ADDR_W-1:0] coreAddr,
    input  logic [DATA_W-1:0] coreWData,
    input  logic [MASK_W-1:0] coreMask,
    output logic coreBusy,
    output logic coreRespValid,
    output logic [DATA_W-1:0] coreRData,
    // memory side
    output logic memReq,
    output logic memWrite,
    output logic [ADDR_W-1:0] memAddr,
    output logic [DATA_W-1:0] memWData,
    output logic [MASK_W-1:0] memMask,
    input  logic memRespValid,
    input  logic [DATA_W-1:0] memRData,
    // register port
    input  logic cfgWrite,
    input  logic [CFG_ADDR_W-1:0] cfgAddr,
    input  logic [DATA_W-1:0] cfgWData,
    output logic [DATA_W-1:0] cfgRData
);

    lookupIf #(.INDEX_BITS(INDEX_BITS)) lk ();
    cfgIf cfg ();

    // tag, valid and data store
    cacheArray #(.INDEX_BITS(INDEX_BITS)) uArray (
        .clk(clk),
        .rst(rst),
        .lk(lk.slave)
    );

    // request sequencer, owns both the core and the memory port
    refillUnit #(.INDEX_BITS(INDEX_BITS)) uRefill (
        .clk(clk),
        .rst(rst),
        .lk(lk.master),
        .cfg(cfg.refill),
        .coreReq(coreReq),
        .coreWrite(coreWrite),
        .coreAddr(coreAddr),
        .coreWData(coreWData),
        .coreMask(coreMask),
        .coreBusy(coreBusy),
        .coreRespValid(coreRespValid),
        .coreRData(coreRData),
        .memReq(memReq),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memWData(memWData),
        .memMask(memMask),
        .memRespValid(memRespValid),
        .memRData(memRData)
    );

    // enable, flush and statistics
    cacheCtrlRegs #(.CNT_BITS(CNT_BITS)) uRegs (
        .clk(clk),
        .rst(rst),
        .cfg(cfg.regs),
        .cfgWrite(cfgWrite),
        .cfgAddr(cfgAddr),
        .cfgWData(cfgWData),
        .cfgRData(cfgRData)
    );

endmodule

// ==== src/lookupIf.sv ====
`timescale 1ns/1ps

interface lookupIf import cachePkg::*; #(
    parameter int INDEX_BITS = 2
);

    // address under lookup, the array answers in the same cycle
    logic [ADDR_W-1:0] lookupAddr;
    logic hit;
    logic [DATA_W-1:0] hitData;

    // line fill, tag and index are taken from fillAddr
    logic fill;
    logic [ADDR_W-1:0] fillAddr;
    logic [DATA_W-1:0] fillData;

    // single line drop, only the set index is carried
    logic inval;
    logic [INDEX_BITS-1:0] invalAddr;

    // clears every valid bit
    logic flushAll;

    modport master (
        output lookupAddr, fill, fillAddr, fillData, inval, invalAddr, flushAll,
        input  hit, hitData
    );

    modport slave (
        input  lookupAddr, fill, fillAddr, fillData, inval, invalAddr, flushAll,
        output hit, hitData
    );

endinterface

// ==== src/refillUnit.sv ====
`timescale 1ns/1ps

module refillUnit import cachePkg::*; #(
    parameter int INDEX_BITS = 2
) (
    input  logic clk,
    input  logic rst,
    lookupIf.master lk,
    cfgIf.refill cfg,
    // core side
    input  logic coreReq,
    input  logic coreWrite,
    input  logic [ADDR_W-1:0] coreAddr,
    input  logic [DATA_W-1:0] coreWData,
    input  logic [MASK_W-1:0] coreMask,
    output logic coreBusy,
    output logic coreRespValid,
    output logic [DATA_W-1:0] coreRData,
    // memory side
    output logic memReq,
    output logic memWrite,
    output logic [ADDR_W-1:0] memAddr,
    output logic [DATA_W-1:0] memWData,
    output logic [MASK_W-1:0] memMask,
    input  logic memRespValid,
    input  logic [DATA_W-1:0] memRData
);

    // sequencer states
    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] RESP_HIT = 2'd1;
    localparam logic [1:0] WAIT_MEM = 2'd2;
    localparam logic [1:0] RESP_MEM = 2'd3;

    logic [1:0] state;
    logic memReqR;
    logic fillR;
    logic invalR;

    // latched request
    logic [ADDR_W-1:0] reqAddr;
    logic reqWrite;
    logic [DATA_W-1:0] reqWData;
    logic [MASK_W-1:0] reqMask;
    logic [DATA_W-1:0] rData;

    logic accept;
    logic useCache;
    logic memDone;

    assign accept = (state == IDLE) && coreReq;
    // read served by the array only while the cache is on
    assign useCache = cfg.enable && lk.hit && !coreWrite;
    assign memDone = (state == WAIT_MEM) && memRespValid;

    // lookup runs on the live core address in the accept cycle
    assign lk.lookupAddr = coreAddr;

    // statistics pulses, misses count only while enabled
    assign cfg.hitEvent = accept && useCache;
    assign cfg.missEvent = accept && !coreWrite && cfg.enable && !lk.hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            memReqR <= 1'b0;
            fillR <= 1'b0;
            invalR <= 1'b0;
        end else begin
            // strobes last one cycle
            memReqR <= 1'b0;
            fillR <= 1'b0;
            invalR <= 1'b0;
            case (state)
                IDLE: begin
                    if (coreReq) begin
                        if (useCache) begin
                            state <= RESP_HIT;
                        end else begin
                            // misses, disabled reads and all stores go out
                            state <= WAIT_MEM;
                            memReqR <= 1'b1;
                            invalR <= coreWrite;
                        end
                    end
                end
                RESP_HIT: state <= IDLE;
                WAIT_MEM: begin
                    if (memRespValid) begin
                        state <= RESP_MEM;
                        fillR <= cfg.enable && !reqWrite;
                    end
                end
                RESP_MEM: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request payload and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            reqAddr <= coreAddr;
            reqWrite <= coreWrite;
            reqWData <= coreWData;
            reqMask <= coreMask;
        end
        if (accept && useCache) begin
            rData <= lk.hitData;
        end else if (memDone) begin
            rData <= memRData;
        end
    end

    // fill uses the word just returned, same one the core sees
    assign lk.fill = fillR;
    assign lk.fillAddr = reqAddr;
    assign lk.fillData = rData;
    assign lk.inval = invalR;
    assign lk.invalAddr = reqAddr[OFFSET_BITS +: INDEX_BITS];
    assign lk.flushAll = cfg.flushReq;

    assign coreBusy = (state != IDLE);
    assign coreRespValid = (state == RESP_HIT) || (state == RESP_MEM);
    assign coreRData = rData;

    assign memReq = memReqR;
    assign memWrite = memReqR && reqWrite;
    assign memAddr = reqAddr;
    assign memWData = reqWData;
    assign memMask = reqMask;

endmodule
